// File: Makefile
VERILATOR    ?= verilator
TOP          ?= mcu_bridge_tb
FILELIST     ?= project.f
OBJ_DIR      ?= obj_dir
COMMON_FLAGS ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS   ?= --lint-only
SIM_FLAGS    ?= --binary
PASS_MSG     := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mcu_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bridge_tb;
  import mcu_cmd_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 10;
  localparam int          SYSCLK_HALF  = 60;
  localparam int          SPI_HALF     = 20;
  localparam int          BYTE_CYCLES  = 16 * SPI_HALF;
  localparam int          N_WR         = 8;
  localparam int          N_REPEAT     = 5;
  localparam int          N_CHEAT      = 3;
  localparam int          N_ECHO       = 4;
  localparam logic [31:0] LFSR_SEED    = 32'h774761d7;
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
  localparam logic [23:0] BURST_ADDR   = 24'h5C0F80;
  localparam logic [7:0]  SIGNATURE    = 8'hA5;
  localparam logic [31:0] FREQ_NOM     = CLK_TEST_WINDOW * CLK_PERIOD / (2 * SYSCLK_HALF);

  // bytes per test group in test order
  localparam int SPI_BYTES = 13 + 2 * (4 + 1 + N_WR) + (4 + 1 + N_REPEAT) + 6 * N_CHEAT
                           + 2 + (N_ECHO + 2) + 6;
  // factor 2 covers select gaps and reset
  localparam int TIMEOUT_CYCLES = 2 * SPI_BYTES * BYTE_CYCLES + 2 * CLK_TEST_WINDOW;

  wire             clk;
  wire             rst_n;
  logic            sck;
  logic            ss_n;
  logic            mosi;
  logic            sysclk;
  wire             miso;
  wire mcu_cfg_t   cfg;
  wire cheat_pgm_t cheat_pgm;
  wire             cheat_pgm_we;

  logic [31:0] lfsr;
  logic [7:0]  tx_buf [16];
  logic [7:0]  rx_buf [16];
  logic [7:0]  burst_data [N_WR];
  int          cycle_cnt = 0;
  int          we_total = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mcu_bridge_top mcu_bridge_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .ss_n         (ss_n),
    .mosi         (mosi),
    .sysclk       (sysclk),
    .miso         (miso),
    .cfg          (cfg),
    .cheat_pgm    (cheat_pgm),
    .cheat_pgm_we (cheat_pgm_we)
  );

  // console clock offset from clk edges
  initial begin
    sysclk = 1'b0;
    #7;
    forever #SYSCLK_HALF sysclk = ~sysclk;
  end

  always @(negedge clk) begin
    if (cheat_pgm_we) begin
      we_total <= we_total + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic rand_byte(output logic [7:0] b);
    int i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cfg(input mcu_cfg_t got, input mcu_cfg_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s cfg got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cheat(input cheat_pgm_t got, input cheat_pgm_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s cheat got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("ERROR at %0t ns: %s count %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_freq(input logic [31:0] got, input logic [31:0] lo,
                            input logic [31:0] hi);
    if (got < lo || got > hi) begin
      $display("ERROR at %0t ns: clock frequency %0d outside %0d..%0d", $time, got, lo, hi);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // SPI master in mode 0 with msb first
  ////////////////////////////////////////////////////////////////////////////

  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] shreg;
    int         i;
    shreg = '0;
    for (i = 7; i >= 0; i--) begin
      mosi <= tx[i];
      wait_cycles(SPI_HALF);
      shreg = {shreg[6:0], miso};
      sck <= 1'b1;
      wait_cycles(SPI_HALF);
      sck <= 1'b0;
    end
    rx = shreg;
  endtask

  task automatic spi_txn(input int nbytes);
    logic [7:0] rx_val;
    int         k;
    @(posedge clk);
    ss_n <= 1'b0;
    wait_cycles(SPI_HALF);
    for (k = 0; k < nbytes; k++) begin
      spi_xfer(tx_buf[k], rx_val);
      rx_buf[k] = rx_val;
    end
    wait_cycles(SPI_HALF);
    ss_n <= 1'b1;
    wait_cycles(2 * SPI_HALF);
  endtask

  task automatic load_ptr(input logic [23:0] addr);
    tx_buf[0] = 8'h00;
    tx_buf[1] = addr[23:16];
    tx_buf[2] = addr[15:8];
    tx_buf[3] = addr[7:0];
    spi_txn(4);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_cfg();
    mcu_cfg_t   exp;
    logic [7:0] b;
    int         k;
    exp = '0;
    exp.mapper = MAPPER_RESET;
    check_cfg(cfg, exp, "after reset");
    tx_buf[0] = 8'h33;
    spi_txn(1);
    exp.mapper = tx_buf[0][2:0];
    check_cfg(cfg, exp, "mapper");
    tx_buf[0] = 8'h15;
    for (k = 1; k <= 3; k++) begin
      rand_byte(b);
      tx_buf[k] = b;
    end
    spi_txn(4);
    exp.rom_mask = {tx_buf[1], tx_buf[2], tx_buf[3]};
    check_cfg(cfg, exp, "rom mask");
    tx_buf[0] = 8'h2C;
    for (k = 1; k <= 3; k++) begin
      rand_byte(b);
      tx_buf[k] = b;
    end
    spi_txn(4);
    exp.saveram_mask = {tx_buf[1], tx_buf[2], tx_buf[3]};
    check_cfg(cfg, exp, "save-RAM mask");
    tx_buf[0] = 8'hED;
    rand_byte(b);
    tx_buf[1] = b;
    spi_txn(2);
    exp.featurebits = tx_buf[1];
    check_cfg(cfg, exp, "feature bits");
    // bit 0 set so the region visibly changes
    tx_buf[0] = 8'hEE;
    rand_byte(b);
    tx_buf[1] = b | 8'h01;
    spi_txn(2);
    exp.region = tx_buf[1][0];
    check_cfg(cfg, exp, "region");
  endtask

  task automatic test_mem_burst();
    logic [7:0] b;
    int         k;
    load_ptr(BURST_ADDR);
    tx_buf[0] = 8'h98;
    for (k = 0; k < N_WR; k++) begin
      rand_byte(b);
      burst_data[k] = b;
      tx_buf[k + 1] = b;
    end
    spi_txn(N_WR + 1);
    load_ptr(BURST_ADDR);
    tx_buf[0] = 8'h88;
    for (k = 1; k <= N_WR; k++) begin
      tx_buf[k] = 8'h00;
    end
    spi_txn(N_WR + 1);
    // reply lags one byte
    for (k = 0; k < N_WR; k++) begin
      check_byte(rx_buf[k + 1], burst_data[k], $sformatf("burst read byte %0d", k));
    end
  endtask

  task automatic test_mem_hold();
    int k;
    load_ptr(BURST_ADDR + 24'd2);
    tx_buf[0] = 8'h80;
    for (k = 1; k <= N_REPEAT; k++) begin
      tx_buf[k] = 8'h00;
    end
    spi_txn(N_REPEAT + 1);
    for (k = 1; k <= N_REPEAT; k++) begin
      check_byte(rx_buf[k], burst_data[2], $sformatf("fixed read byte %0d", k));
    end
  endtask

  task automatic test_cheat();
    cheat_pgm_t exp;
    logic [7:0] b;
    int         we_start;
    int         n;
    int         k;
    for (n = 0; n < N_CHEAT; n++) begin
      tx_buf[0] = 8'hD3;
      for (k = 1; k <= 5; k++) begin
        rand_byte(b);
        tx_buf[k] = b;
      end
      we_start = we_total;
      spi_txn(6);
      exp.idx  = tx_buf[1][2:0];
      exp.data = {tx_buf[2], tx_buf[3], tx_buf[4], tx_buf[5]};
      check_cheat(cheat_pgm, exp, $sformatf("slot program %0d", n));
      check_count(we_total - we_start, 1, "cheat write enable");
    end
  endtask

  task automatic test_readback();
    logic [7:0]  b;
    logic [31:0] freq;
    int          k;
    tx_buf[0] = 8'hF0;
    tx_buf[1] = 8'h00;
    spi_txn(2);
    check_byte(rx_buf[1], SIGNATURE, "signature");
    // one trailing byte to shift out the last echo
    tx_buf[0] = 8'hFF;
    for (k = 1; k <= N_ECHO + 1; k++) begin
      rand_byte(b);
      tx_buf[k] = b;
    end
    spi_txn(N_ECHO + 2);
    for (k = 1; k <= N_ECHO; k++) begin
      check_byte(rx_buf[k + 1], tx_buf[k], $sformatf("echo byte %0d", k));
    end
    wait_cycles(2 * CLK_TEST_WINDOW);
    tx_buf[0] = 8'hFE;
    for (k = 1; k <= 5; k++) begin
      tx_buf[k] = 8'h00;
    end
    spi_txn(6);
    freq = {rx_buf[2], rx_buf[3], rx_buf[4], rx_buf[5]};
    check_freq(freq, FREQ_NOM - 32'd1, FREQ_NOM + 32'd1);
  endtask

  initial begin
    lfsr = LFSR_SEED;
    sck  <= 1'b0;
    ss_n <= 1'b1;
    mosi <= 1'b0;
    @(posedge rst_n);
    wait_cycles(4);
    test_cfg();
    test_mem_burst();
    test_mem_hold();
    test_cheat();
    test_readback();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/mcu_cmd_pkg.sv
verilog/spi_byte_slave.sv
verilog/mcu_cmd.sv
verilog/clk_test.sv
verilog/mcu_mem_port.sv
verilog/mcu_bridge_top.sv
dv/tb_clk_gen.sv
dv/mcu_bridge_tb.sv

// File: verilog/clk_test.sv
`timescale 1ns/1ps
`default_nettype none

module clk_test (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         sysclk,
  output logic [31:0] sysclk_freq
);
  import mcu_cmd_pkg::*;

  logic [2:0]                sys_sr;
  logic                      sys_rise;
  logic [CLK_TEST_CNT_W-1:0] win_cnt;
  logic [31:0]               edge_cnt;

  assign sys_rise = sys_sr[1] & ~sys_sr[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_sr      <= '0;
      win_cnt     <= '0;
      edge_cnt    <= '0;
      sysclk_freq <= '0;
    end else begin
      sys_sr <= {sys_sr[1:0], sysclk};
      if (win_cnt == CLK_TEST_CNT_W'(CLK_TEST_WINDOW - 1)) begin
        // end of window, publish and restart
        win_cnt     <= '0;
        sysclk_freq <= edge_cnt + {31'd0, sys_rise};
        edge_cnt    <= '0;
      end else begin
        win_cnt  <= win_cnt + 1'b1;
        edge_cnt <= edge_cnt + {31'd0, sys_rise};
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mcu_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bridge_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          sck,
  input  wire                          ss_n,
  input  wire                          mosi,
  input  wire                          sysclk,
  output wire                          miso,
  output wire mcu_cmd_pkg::mcu_cfg_t   cfg,
  output wire mcu_cmd_pkg::cheat_pgm_t cheat_pgm,
  output wire                          cheat_pgm_we
);
  import mcu_cmd_pkg::*;

  spi_frame_t  frame;
  wire         cmd_ready;
  wire         param_ready;
  wire [7:0]   reply_byte;
  mem_rq_t     mem_rq;
  wire         mem_rrq;
  wire         mem_wrq;
  wire         mem_rdy;
  wire [7:0]   mem_rdata;
  wire [31:0]  sysclk_freq;

  ////////////////////////////////////////////////////////////////////////////
  // SPI framing, command decode, console clock meter, memory
  ////////////////////////////////////////////////////////////////////////////

  spi_byte_slave spi_byte_slave_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .reply_byte  (reply_byte),
    .miso        (miso),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .frame       (frame)
  );

  mcu_cmd mcu_cmd_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .frame        (frame),
    .mem_rdy      (mem_rdy),
    .mem_rdata    (mem_rdata),
    .sysclk_freq  (sysclk_freq),
    .reply_byte   (reply_byte),
    .mem_rq       (mem_rq),
    .mem_rrq      (mem_rrq),
    .mem_wrq      (mem_wrq),
    .cfg          (cfg),
    .cheat_pgm    (cheat_pgm),
    .cheat_pgm_we (cheat_pgm_we)
  );

  clk_test clk_test_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sysclk      (sysclk),
    .sysclk_freq (sysclk_freq)
  );

  mcu_mem_port mcu_mem_port_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_rq    (mem_rq),
    .mem_rrq   (mem_rrq),
    .mem_wrq   (mem_wrq),
    .mem_rdy   (mem_rdy),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: verilog/mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          cmd_ready,
  input  wire                          param_ready,
  input  wire mcu_cmd_pkg::spi_frame_t frame,
  input  wire                          mem_rdy,
  input  wire [7:0]                    mem_rdata,
  input  wire [31:0]                   sysclk_freq,
  output logic [7:0]                   reply_byte,
  output mcu_cmd_pkg::mem_rq_t         mem_rq,
  output logic                         mem_rrq,
  output logic                         mem_wrq,
  output mcu_cmd_pkg::mcu_cfg_t        cfg,
  output mcu_cmd_pkg::cheat_pgm_t      cheat_pgm,
  output logic                         cheat_pgm_we
);
  import mcu_cmd_pkg::*;

  logic [1:0]  rdy_sr;
  logic        next_addr;
  logic        auto_inc;
  logic [31:0] freq_buf;

  // big-endian load of a 24 bit value from bytes 2..4
  function automatic logic [ADDR_W-1:0] load_be24(input logic [ADDR_W-1:0] cur,
                                                  input logic [7:0]        cnt,
                                                  input logic [7:0]        din);
    logic [ADDR_W-1:0] nxt;
    nxt = cur;
    case (cnt)
      8'd2: nxt[23:16] = din;
      8'd3: nxt[15:8] = din;
      8'd4: nxt[7:0] = din;
      default: ;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '{mapper: MAPPER_RESET, default: '0};
    end else if (cmd_ready) begin
      if (frame.cmd[7:4] == 4'h3) begin
        cfg.mapper <= frame.cmd[2:0];
      end
    end else if (param_ready) begin
      casez (frame.cmd)
        8'h1?: cfg.rom_mask <= load_be24(cfg.rom_mask, frame.byte_cnt, frame.data);
        8'h2?: cfg.saveram_mask <= load_be24(cfg.saveram_mask, frame.byte_cnt, frame.data);
        8'hED: cfg.featurebits <= frame.data;
        8'hEE: cfg.region <= frame.data[0];
        default: ;
      endcase
    end
  end

  // cheat slot, write enable on the last data byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cheat_pgm    <= '0;
      cheat_pgm_we <= 1'b0;
    end else begin
      cheat_pgm_we <= 1'b0;
      if (param_ready && frame.cmd == 8'hD3) begin
        case (frame.byte_cnt)
          8'd2: cheat_pgm.idx <= frame.data[2:0];
          8'd3: cheat_pgm.data[31:24] <= frame.data;
          8'd4: cheat_pgm.data[23:16] <= frame.data;
          8'd5: cheat_pgm.data[15:8] <= frame.data;
          8'd6: begin
            cheat_pgm.data[7:0] <= frame.data;
            cheat_pgm_we        <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory pointer and requests
  ////////////////////////////////////////////////////////////////////////////

  // ready rise seen one cycle late, data already held by the port
  assign next_addr = (rdy_sr == 2'b01);
  assign auto_inc  = next_addr && (frame.cmd[7:5] == 3'b100) && frame.cmd[3];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rq  <= '0;
      mem_rrq <= 1'b0;
      mem_wrq <= 1'b0;
      rdy_sr  <= 2'b11;
    end else begin
      rdy_sr  <= {rdy_sr[0], mem_rdy};
      mem_rrq <= (cmd_ready || param_ready) && (frame.cmd[7:4] == 4'h8);
      mem_wrq <= param_ready && (frame.cmd[7:4] == 4'h9);
      if (param_ready && frame.cmd[7:4] == 4'h9) begin
        mem_rq.wdata <= frame.data;
      end
      if (param_ready && frame.cmd[7:4] == 4'h0) begin
        // first address byte clears the low part
        if (frame.byte_cnt == 8'd2) begin
          mem_rq.addr <= {frame.data, 16'h0000};
        end else begin
          mem_rq.addr <= load_be24(mem_rq.addr, frame.byte_cnt, frame.data);
        end
      end else if (auto_inc) begin
        mem_rq.addr <= mem_rq.addr + ADDR_W'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reply byte, shifted out during the following byte
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply_byte <= '0;
      freq_buf   <= '0;
    end else if (next_addr && frame.cmd[7:4] == 4'h8) begin
      reply_byte <= mem_rdata;
    end else if (cmd_ready || param_ready) begin
      case (frame.cmd)
        8'hF0: reply_byte <= CMD_SIGNATURE;
        8'hFE: begin
          case (frame.byte_cnt)
            8'd1: freq_buf <= sysclk_freq;
            8'd2: reply_byte <= freq_buf[31:24];
            8'd3: reply_byte <= freq_buf[23:16];
            8'd4: reply_byte <= freq_buf[15:8];
            8'd5: reply_byte <= freq_buf[7:0];
            default: ;
          endcase
        end
        8'hFF: reply_byte <= frame.data;
        default: ;
      endcase
    end
  end

  rq_excl_a : assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rrq && mem_wrq));

endmodule

`default_nettype wire

// File: verilog/mcu_cmd_pkg.sv
`default_nettype none

package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W          = 24;
  localparam int MEM_WORDS       = 4096;
  localparam int MEM_IDX_W       = $clog2(MEM_WORDS);
  localparam int MEM_LATENCY     = 4;
  localparam int MEM_LAT_W       = $clog2(MEM_LATENCY);
  localparam int CLK_TEST_WINDOW = 1000;
  localparam int CLK_TEST_CNT_W  = $clog2(CLK_TEST_WINDOW);

  // fixed reply to 0xF0
  localparam logic [7:0] CMD_SIGNATURE = 8'hA5;
  localparam logic [2:0] MAPPER_RESET  = 3'd1;

  ////////////////////////////////////////////////////////////////////////////
  // bundled signals
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [2:0]        mapper;
    logic [ADDR_W-1:0] rom_mask;
    logic [ADDR_W-1:0] saveram_mask;
    logic [7:0]        featurebits;
    logic              region;
  } mcu_cfg_t;

  typedef struct packed {
    logic [2:0]  idx;
    logic [31:0] data;
  } cheat_pgm_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
  } mem_rq_t;

  // byte_cnt is 1 for the command byte
  typedef struct packed {
    logic [7:0] byte_cnt;
    logic [7:0] cmd;
    logic [7:0] data;
    logic [2:0] bit_cnt;
  } spi_frame_t;

endpackage

`default_nettype wire

// File: verilog/mcu_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_mem_port (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire mcu_cmd_pkg::mem_rq_t mem_rq,
  input  wire                       mem_rrq,
  input  wire                       mem_wrq,
  output logic                      mem_rdy,
  output logic [7:0]                mem_rdata
);
  import mcu_cmd_pkg::*;

  logic [7:0]           mem [MEM_WORDS];
  mem_rq_t              pend_rq;
  logic                 pend_wr;
  logic [MEM_LAT_W-1:0] lat_cnt;
  logic                 done;

  // last busy cycle, access happens here
  assign done = !mem_rdy && (lat_cnt == MEM_LAT_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rdy <= 1'b1;
      lat_cnt <= '0;
      pend_wr <= 1'b0;
    end else if (mem_rrq || mem_wrq) begin
      mem_rdy <= 1'b0;
      lat_cnt <= MEM_LAT_W'(MEM_LATENCY - 1);
      pend_wr <= mem_wrq;
    end else if (!mem_rdy) begin
      lat_cnt <= lat_cnt - 1'b1;
      mem_rdy <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rrq || mem_wrq) begin
      pend_rq <= mem_rq;
    end
    if (done) begin
      if (pend_wr) begin
        mem[pend_rq.addr[MEM_IDX_W-1:0]] <= pend_rq.wdata;
      end else begin
        mem_rdata <= mem[pend_rq.addr[MEM_IDX_W-1:0]];
      end
    end
  end

  no_rq_busy_a : assert property (@(posedge clk) disable iff (!rst_n)
    (mem_rrq || mem_wrq) |-> mem_rdy);

endmodule

`default_nettype wire

// File: verilog/spi_byte_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_slave (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     sck,
  input  wire                     ss_n,
  input  wire                     mosi,
  input  wire [7:0]               reply_byte,
  output wire                     miso,
  output logic                    cmd_ready,
  output logic                    param_ready,
  output mcu_cmd_pkg::spi_frame_t frame
);
  import mcu_cmd_pkg::*;

  logic [2:0] sck_sr;
  logic [1:0] ss_sr;
  logic [1:0] mosi_sr;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_act;
  logic [6:0] rx_sr;
  logic [7:0] rx_byte;
  logic [7:0] tx_sr;
  logic       tx_load;

  // two-flop sync, third sck stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sr  <= '0;
      ss_sr   <= '1;
      mosi_sr <= '0;
    end else begin
      sck_sr  <= {sck_sr[1:0], sck};
      ss_sr   <= {ss_sr[0], ss_n};
      mosi_sr <= {mosi_sr[0], mosi};
    end
  end

  assign sck_rise = sck_sr[1] & ~sck_sr[2];
  assign sck_fall = ~sck_sr[1] & sck_sr[2];
  assign ss_act   = ~ss_sr[1];
  assign rx_byte  = {rx_sr, mosi_sr[1]};

  ////////////////////////////////////////////////////////////////////////////
  // receive, msb first
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame       <= '0;
      rx_sr       <= '0;
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
    end else begin
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      if (!ss_act) begin
        frame.byte_cnt <= '0;
        frame.bit_cnt  <= '0;
      end else if (sck_rise) begin
        rx_sr         <= rx_byte[6:0];
        frame.bit_cnt <= frame.bit_cnt + 3'd1;
        if (frame.bit_cnt == 3'd7) begin
          frame.data <= rx_byte;
          // saturate so long bursts never look like a new command
          if (frame.byte_cnt != 8'hFF) begin
            frame.byte_cnt <= frame.byte_cnt + 8'd1;
          end
          if (frame.byte_cnt == 8'd0) begin
            frame.cmd <= rx_byte;
            cmd_ready <= 1'b1;
          end else begin
            param_ready <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit, reply loaded on first falling edge after a byte
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_sr   <= '0;
      tx_load <= 1'b0;
    end else if (!ss_act) begin
      tx_sr   <= '0;
      tx_load <= 1'b0;
    end else if (sck_fall) begin
      tx_load <= 1'b0;
      tx_sr   <= tx_load ? reply_byte : {tx_sr[6:0], 1'b0};
    end else if (cmd_ready || param_ready) begin
      tx_load <= 1'b1;
    end
  end

  assign miso = tx_sr[7];

  strobe_excl_a : assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_ready && param_ready));

endmodule

`default_nettype wire
